//--- hw/bitmanip_pkg.sv
/* Shared width constants, operand type and the unit, opcode and
   count-state enums for the bit-manipulation coprocessor */
`default_nettype none

package bitmanip_pkg;

	localparam int XLEN    = 32;                 // Data width
	localparam int SHAMT_W = 5;                  // Shift amount bits

	typedef logic [XLEN-1:0] word_t;

	// Functional unit that receives a decoded instruction
	typedef enum logic [1:0] {
		UNIT_NONE,
		UNIT_LOGIC,
		UNIT_SHIFT,
		UNIT_COUNT
	} unit_e;

	typedef enum logic [3:0] {
		OP_ANDN,
		OP_ORN,
		OP_XNOR,
		OP_MIN,
		OP_MAX,
		OP_MINU,
		OP_MAXU,
		OP_PACK,
		OP_SLL,                                  // Also SLLI
		OP_SRL,                                  // Also SRLI
		OP_SRA,                                  // Also SRAI
		OP_ROL,
		OP_ROR,                                  // Also RORI
		OP_CLZ,
		OP_CTZ,
		OP_PCNT
	} op_e;

	typedef enum logic [1:0] {
		CNT_IDLE,
		CNT_RUN,
		CNT_DONE
	} count_state_e;

endpackage

`default_nettype wire

//--- hw/unit_if.sv
/* Request and result channel between the issue stage, one functional
   unit and the result stage */
`timescale 1ns/1ps
`default_nettype none

interface unit_if
	import bitmanip_pkg::*;
();

	logic  req_valid;                            // Held until req_done
	op_e   op;
	word_t rs1;
	word_t rs2;
	logic  req_done;                             // Unit has taken the request
	logic  res_valid;
	word_t result;
	logic  res_ready;

	modport issue (output req_valid, op, rs1, rs2, input req_done);
	modport unit (input req_valid, op, rs1, rs2, res_ready,
		output req_done, res_valid, result);
	modport collect (input res_valid, result, output res_ready);

endinterface

`default_nettype wire

//--- hw/insn_decoder.sv
/* Instruction decoder: maps an RV32 instruction word to a functional
   unit, an opcode and the immediate operand select */
`timescale 1ns/1ps
`default_nettype none

module insn_decoder
	import bitmanip_pkg::*;
(
	input  logic [31:0] insn,
	output unit_e       unit,
	output op_e         op,
	output logic        use_imm,
	output logic        decoded
);

	logic hit;

	always_comb begin
		op = OP_ANDN;
		hit = 1'b1;
		casez (insn)
			// R-type, funct7 / rs2 / rs1 / funct3 / rd / opcode
			32'b0100000_?????_?????_111_?????_0110011: op = OP_ANDN;
			32'b0100000_?????_?????_110_?????_0110011: op = OP_ORN;
			32'b0100000_?????_?????_100_?????_0110011: op = OP_XNOR;
			32'b0000101_?????_?????_100_?????_0110011: op = OP_MIN;
			32'b0000101_?????_?????_101_?????_0110011: op = OP_MAX;
			32'b0000101_?????_?????_110_?????_0110011: op = OP_MINU;
			32'b0000101_?????_?????_111_?????_0110011: op = OP_MAXU;
			32'b0000100_?????_?????_100_?????_0110011: op = OP_PACK;
			32'b0000000_?????_?????_001_?????_0110011: op = OP_SLL;
			32'b0000000_?????_?????_101_?????_0110011: op = OP_SRL;
			32'b0100000_?????_?????_101_?????_0110011: op = OP_SRA;
			32'b0110000_?????_?????_001_?????_0110011: op = OP_ROL;
			32'b0110000_?????_?????_101_?????_0110011: op = OP_ROR;
			// I-type, shift amount in bits 24:20
			32'b0000000_?????_?????_001_?????_0010011: op = OP_SLL;
			32'b0000000_?????_?????_101_?????_0010011: op = OP_SRL;
			32'b0100000_?????_?????_101_?????_0010011: op = OP_SRA;
			32'b0110000_?????_?????_101_?????_0010011: op = OP_ROR;
			// Bit counts, selector in bits 24:20
			32'b0110000_00000_?????_001_?????_0010011: op = OP_CLZ;
			32'b0110000_00001_?????_001_?????_0010011: op = OP_CTZ;
			32'b0110000_00010_?????_001_?????_0010011: op = OP_PCNT;
			default: hit = 1'b0;
		endcase
	end

	always_comb begin
		unit = UNIT_NONE;
		if (hit) begin
			case (op)
				OP_ANDN, OP_ORN, OP_XNOR, OP_MIN, OP_MAX, OP_MINU, OP_MAXU, OP_PACK:
					unit = UNIT_LOGIC;
				OP_CLZ, OP_CTZ, OP_PCNT:
					unit = UNIT_COUNT;
				default:
					unit = UNIT_SHIFT;
			endcase
		end
	end

	// Immediate shifts take their amount from the instruction
	assign use_imm = (unit == UNIT_SHIFT) && (insn[6:0] == 7'b0010011);
	assign decoded = hit;

endmodule

`default_nettype wire

//--- hw/issue_stage.sv
/* Issue stage: input handshake, operand register, busy flag and
   request dispatch to the logic, shift and count units */
`timescale 1ns/1ps
`default_nettype none

module issue_stage
	import bitmanip_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        din_valid,
	input  word_t       din_rs1,
	input  word_t       din_rs2,
	input  logic [31:0] din_insn,
	output logic        din_ready,
	output logic        din_decoded,
	unit_if.issue       logic_req,
	unit_if.issue       shift_req,
	unit_if.issue       count_req,
	input  logic        done_any
);

	unit_e unit;
	op_e   op;
	logic  use_imm;
	logic  accept;
	logic  busy;
	logic  logic_pend, shift_pend, count_pend;
	op_e   op_q;
	word_t rs1_q, rs2_q;

	insn_decoder u_decoder (
		.insn    (din_insn),
		.unit    (unit),
		.op      (op),
		.use_imm (use_imm),
		.decoded (din_decoded)
	);

	assign din_ready = !reset && !busy && din_decoded;
	assign accept = din_valid && din_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			logic_pend <= 1'b0;
			shift_pend <= 1'b0;
			count_pend <= 1'b0;
		end else begin
			if (logic_req.req_done)
				logic_pend <= 1'b0;
			if (shift_req.req_done)
				shift_pend <= 1'b0;
			if (count_req.req_done)
				count_pend <= 1'b0;
			if (accept) begin
				logic_pend <= (unit == UNIT_LOGIC);
				shift_pend <= (unit == UNIT_SHIFT);
				count_pend <= (unit == UNIT_COUNT);
				busy <= 1'b1;
			end else if (done_any) begin
				busy <= 1'b0;                    // Result captured downstream
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op_q <= op;
			rs1_q <= din_rs1;
			if (use_imm)
				rs2_q <= {{(XLEN-SHAMT_W){1'b0}}, din_insn[20 +: SHAMT_W]};
			else
				rs2_q <= din_rs2;
		end
	end

	// Operands go to every unit; only one sees req_valid
	assign logic_req.req_valid = logic_pend;
	assign logic_req.op = op_q;
	assign logic_req.rs1 = rs1_q;
	assign logic_req.rs2 = rs2_q;

	assign shift_req.req_valid = shift_pend;
	assign shift_req.op = op_q;
	assign shift_req.rs1 = rs1_q;
	assign shift_req.rs2 = rs2_q;

	assign count_req.req_valid = count_pend;
	assign count_req.op = op_q;
	assign count_req.rs1 = rs1_q;
	assign count_req.rs2 = rs2_q;

endmodule

`default_nettype wire

//--- hw/logic_unit.sv
/* Single-cycle logic unit: inverted logic ops, signed and unsigned
   min/max, and halfword pack */
`timescale 1ns/1ps
`default_nettype none

module logic_unit
	import bitmanip_pkg::*;
(
	unit_if.unit req
);

	logic  lt_s, lt_u;
	word_t res;

	assign lt_s = $signed(req.rs1) < $signed(req.rs2);
	assign lt_u = req.rs1 < req.rs2;

	always_comb begin
		case (req.op)
			OP_ANDN: res = req.rs1 & ~req.rs2;
			OP_ORN:  res = req.rs1 | ~req.rs2;
			OP_XNOR: res = ~(req.rs1 ^ req.rs2);
			OP_MIN:  res = lt_s ? req.rs1 : req.rs2;
			OP_MAX:  res = lt_s ? req.rs2 : req.rs1;
			OP_MINU: res = lt_u ? req.rs1 : req.rs2;
			OP_MAXU: res = lt_u ? req.rs2 : req.rs1;
			OP_PACK: res = {req.rs2[XLEN/2-1:0], req.rs1[XLEN/2-1:0]};
			default: res = '0;
		endcase
	end

	// Result is ready in the request cycle; operands stay held until taken
	assign req.result = res;
	assign req.res_valid = req.req_valid;
	assign req.req_done = req.req_valid && req.res_ready;

endmodule

`default_nettype wire

//--- hw/shift_unit.sv
/* Single-cycle shift unit: logical and arithmetic shifts and
   rotates by the low bits of rs2 */
`timescale 1ns/1ps
`default_nettype none

module shift_unit
	import bitmanip_pkg::*;
(
	unit_if.unit req
);

	logic [SHAMT_W-1:0] shamt;
	logic [2*XLEN-1:0]  rol_w, ror_w;
	word_t              res;

	assign shamt = req.rs2[SHAMT_W-1:0];

	// Rotate through a doubled word
	assign rol_w = {req.rs1, req.rs1} << shamt;
	assign ror_w = {req.rs1, req.rs1} >> shamt;

	always_comb begin
		case (req.op)
			OP_SLL:  res = req.rs1 << shamt;
			OP_SRL:  res = req.rs1 >> shamt;
			OP_SRA:  res = $signed(req.rs1) >>> shamt;   // Sign fill
			OP_ROL:  res = rol_w[2*XLEN-1:XLEN];
			OP_ROR:  res = ror_w[XLEN-1:0];
			default: res = '0;
		endcase
	end

	assign req.result = res;
	assign req.res_valid = req.req_valid;
	assign req.req_done = req.req_valid && req.res_ready;

endmodule

`default_nettype wire

//--- hw/count_unit.sv
/* Iterative bit-count unit: CLZ, CTZ and PCNT, one bit per cycle */
`timescale 1ns/1ps
`default_nettype none

module count_unit
	import bitmanip_pkg::*;
(
	input  logic clock,
	input  logic reset,
	unit_if.unit req
);

	count_state_e       state;
	op_e                op_q;
	word_t              sreg;                    // Bits still to scan
	logic [SHAMT_W-1:0] idx;                     // Bits examined so far
	logic [SHAMT_W:0]   cnt;                     // Up to 32
	logic               scan_bit, is_pcnt, stop;

	assign is_pcnt = (op_q == OP_PCNT);
	assign scan_bit = (op_q == OP_CLZ) ? sreg[XLEN-1] : sreg[0];

	// CLZ/CTZ end at the first one bit, all ops end after the last bit
	assign stop = (idx == SHAMT_W'(XLEN-1)) || (scan_bit && !is_pcnt);

	assign req.req_done = (state == CNT_IDLE) && req.req_valid;
	assign req.res_valid = (state == CNT_DONE);
	assign req.result = {{(XLEN-SHAMT_W-1){1'b0}}, cnt};

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= CNT_IDLE;
		end else begin
			case (state)
				CNT_IDLE: if (req.req_valid) state <= CNT_RUN;
				CNT_RUN:  if (stop) state <= CNT_DONE;
				CNT_DONE: if (req.res_ready) state <= CNT_IDLE;
				default:  state <= CNT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (req.req_done) begin
			sreg <= req.rs1;
			op_q <= req.op;
			idx <= '0;
			cnt <= '0;
		end else if (state == CNT_RUN) begin
			if (op_q == OP_CLZ)
				sreg <= sreg << 1;               // Scan from the MSB
			else
				sreg <= sreg >> 1;
			idx <= idx + 1'b1;
			// Zeros count for CLZ/CTZ, ones for PCNT
			if (scan_bit == is_pcnt)
				cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/result_stage.sv
/* Result stage: selects the finishing unit and holds the output
   word under back-pressure */
`timescale 1ns/1ps
`default_nettype none

module result_stage
	import bitmanip_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	unit_if.collect logic_res,
	unit_if.collect shift_res,
	unit_if.collect count_res,
	output logic    dout_valid,
	input  logic    dout_ready,
	output word_t   dout_rd,
	output logic    done_any
);

	logic  out_ready, any_valid;
	word_t sel_rd;

	assign out_ready = !dout_valid || dout_ready;
	assign logic_res.res_ready = out_ready;
	assign shift_res.res_ready = out_ready;
	assign count_res.res_ready = out_ready;

	assign any_valid = logic_res.res_valid || shift_res.res_valid || count_res.res_valid;
	assign done_any = out_ready && any_valid;    // Capture this edge

	// At most one unit holds a result at a time
	always_comb begin
		sel_rd = count_res.result;
		if (logic_res.res_valid)
			sel_rd = logic_res.result;
		else if (shift_res.res_valid)
			sel_rd = shift_res.result;
	end

	always_ff @(posedge clock) begin
		if (reset)
			dout_valid <= 1'b0;
		else if (out_ready)
			dout_valid <= any_valid;
	end

	always_ff @(posedge clock) begin
		if (done_any)
			dout_rd <= sel_rd;
	end

endmodule

`default_nettype wire

//--- hw/bitmanip_top.sv
/* Coprocessor top level: issue stage, three functional units and
   the result stage joined by unit channels */
`timescale 1ns/1ps
`default_nettype none

module bitmanip_top (
	input  logic        clock,
	input  logic        reset,
	input  logic        din_valid,
	output logic        din_ready,
	output logic        din_decoded,
	input  logic [31:0] din_rs1,
	input  logic [31:0] din_rs2,
	input  logic [31:0] din_insn,
	output logic        dout_valid,
	input  logic        dout_ready,
	output logic [31:0] dout_rd
);

	logic done_any;                              // Result stage capture

	unit_if logic_if ();
	unit_if shift_if ();
	unit_if count_if ();

	issue_stage u_issue (
		.clock       (clock),
		.reset       (reset),
		.din_valid   (din_valid),
		.din_rs1     (din_rs1),
		.din_rs2     (din_rs2),
		.din_insn    (din_insn),
		.din_ready   (din_ready),
		.din_decoded (din_decoded),
		.logic_req   (logic_if.issue),
		.shift_req   (shift_if.issue),
		.count_req   (count_if.issue),
		.done_any    (done_any)
	);

	logic_unit u_logic (
		.req (logic_if.unit)
	);

	shift_unit u_shift (
		.req (shift_if.unit)
	);

	count_unit u_count (
		.clock (clock),
		.reset (reset),
		.req   (count_if.unit)
	);

	result_stage u_result (
		.clock      (clock),
		.reset      (reset),
		.logic_res  (logic_if.collect),
		.shift_res  (shift_if.collect),
		.count_res  (count_if.collect),
		.dout_valid (dout_valid),
		.dout_ready (dout_ready),
		.dout_rd    (dout_rd),
		.done_any   (done_any)
	);

endmodule

`default_nettype wire

//--- testbench/bitmanip_checker.sv
/* Bound assertions on reset, output hold under back-pressure and
   input stall while the count unit is working */
`timescale 1ns/1ps
`default_nettype none

module bitmanip_checker
	import bitmanip_pkg::*;
(
	input logic         clock,
	input logic         reset,
	input logic         din_ready,
	input logic         dout_valid,
	input logic         dout_ready,
	input logic [31:0]  dout_rd,
	input count_state_e count_state
);

	int fail_count = 0;

	a_reset_idle: assert property (@(posedge clock) reset |=> !dout_valid)
		else begin
			fail_count++;
			$error("dout_valid high after a reset cycle");
		end

	// Output word must not move while the consumer stalls
	a_hold_rd: assert property (@(posedge clock) disable iff (reset)
		dout_valid && !dout_ready |=> dout_valid && $stable(dout_rd))
		else begin
			fail_count++;
			$error("dout_rd or dout_valid changed under back-pressure");
		end

	a_stall: assert property (@(posedge clock) disable iff (reset)
		count_state != CNT_IDLE |-> !din_ready)
		else begin
			fail_count++;
			$error("din_ready high while a count is pending");
		end

endmodule

`default_nettype wire

//--- testbench/bitmanip_tb.sv
/* Directed testbench for the coprocessor: reference model, compare
   task, logic, shift, count, back-pressure and stall tests, watchdog */
`timescale 1ns/1ps
`default_nettype none

module bitmanip_tb
	import bitmanip_pkg::*;
();

	localparam int N_RAND  = 4;                  // Random logic operand sets
	localparam int N_WORDS = 8;                  // Words for the count tests
	localparam int N_TESTS = N_RAND * 8 + 8 + 3 * 9 + N_WORDS * 3 + 5;
	localparam int CYCLES_PER_TEST = 200;

	logic        clock, reset, din_valid, din_ready, din_decoded;
	logic        dout_valid, dout_ready;
	logic [31:0] din_rs1, din_rs2, din_insn, dout_rd;

	bitmanip_top u_dut (
		.clock       (clock),
		.reset       (reset),
		.din_valid   (din_valid),
		.din_ready   (din_ready),
		.din_decoded (din_decoded),
		.din_rs1     (din_rs1),
		.din_rs2     (din_rs2),
		.din_insn    (din_insn),
		.dout_valid  (dout_valid),
		.dout_ready  (dout_ready),
		.dout_rd     (dout_rd)
	);

	bind bitmanip_top bitmanip_checker u_checker (
		.clock       (clock),
		.reset       (reset),
		.din_ready   (din_ready),
		.dout_valid  (dout_valid),
		.dout_ready  (dout_ready),
		.dout_rd     (dout_rd),
		.count_state (u_count.state)
	);

	always #4 clock = ~clock;                    // 8 ns period

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3);
		return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] f7, input logic [4:0] imm,
		input logic [2:0] f3);
		return {f7, imm, 5'd1, f3, 5'd3, 7'b0010011};
	endfunction

	function automatic logic [31:0] expected_result(input op_e op, input logic [31:0] a,
		input logic [31:0] b);
		logic [4:0]  s;
		logic [31:0] r;
		logic        seen;
		int          i;
		s = b[4:0];
		r = '0;
		seen = 1'b0;
		case (op)
			OP_ANDN: r = a & ~b;
			OP_ORN:  r = a | ~b;
			OP_XNOR: r = a ~^ b;
			OP_MIN:  r = ($signed(a) < $signed(b)) ? a : b;
			OP_MAX:  r = ($signed(a) > $signed(b)) ? a : b;
			OP_MINU: r = (a < b) ? a : b;
			OP_MAXU: r = (a > b) ? a : b;
			OP_PACK: r = {b[15:0], a[15:0]};
			OP_SLL:  r = a << s;
			OP_SRL:  r = a >> s;
			OP_SRA:  r = $signed(a) >>> s;
			OP_ROL:  r = (s == 0) ? a : (a << s) | (a >> (32 - s));
			OP_ROR:  r = (s == 0) ? a : (a >> s) | (a << (32 - s));
			OP_CLZ: begin
				for (i = 31; i >= 0; i--) begin
					seen = seen | a[i];
					if (!seen)
						r++;
				end
			end
			OP_CTZ: begin
				for (i = 0; i < 32; i++) begin
					seen = seen | a[i];
					if (!seen)
						r++;
				end
			end
			OP_PCNT: begin
				for (i = 0; i < 32; i++)
					r = r + a[i];
			end
			default: r = 'x;
		endcase
		return r;
	endfunction

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at time %0t: %s returned %h, expected %h", $time, what, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "Stopped on the first mismatch");
		end
	endtask

	// Returns right after the accepting edge
	task automatic send_insn(input logic [31:0] insn, input logic [31:0] a,
		input logic [31:0] b);
		@(posedge clock);
		din_valid <= 1'b1;
		din_insn <= insn;
		din_rs1 <= a;
		din_rs2 <= b;
		@(negedge clock);
		while (!din_ready)
			@(negedge clock);
		@(posedge clock);
		din_valid <= 1'b0;
	endtask

	task automatic wait_result(output logic [31:0] rd);
		@(negedge clock);
		while (!dout_valid)
			@(negedge clock);
		rd = dout_rd;
	endtask

	task automatic run_check(input logic [31:0] insn, input op_e op, input logic [31:0] a,
		input logic [31:0] b, input string name);
		logic [31:0] b_eff;
		logic [31:0] rd;
		b_eff = (insn[6:0] == 7'b0010011) ? {27'd0, insn[24:20]} : b;   // Immediate form
		send_insn(insn, a, b);
		wait_result(rd);
		check_equal(name, rd, expected_result(op, a, b_eff));
	endtask

	task automatic run_logic_set(input logic [31:0] a, input logic [31:0] b);
		run_check(r_type(7'b0100000, 3'b111), OP_ANDN, a, b, "ANDN");
		run_check(r_type(7'b0100000, 3'b110), OP_ORN, a, b, "ORN");
		run_check(r_type(7'b0100000, 3'b100), OP_XNOR, a, b, "XNOR");
		run_check(r_type(7'b0000101, 3'b100), OP_MIN, a, b, "MIN");
		run_check(r_type(7'b0000101, 3'b101), OP_MAX, a, b, "MAX");
		run_check(r_type(7'b0000101, 3'b110), OP_MINU, a, b, "MINU");
		run_check(r_type(7'b0000101, 3'b111), OP_MAXU, a, b, "MAXU");
		run_check(r_type(7'b0000100, 3'b100), OP_PACK, a, b, "PACK");
	endtask

	task automatic test_logic();
		int k;
		for (k = 0; k < N_RAND; k++)
			run_logic_set($urandom, $urandom);
		run_logic_set(32'h8000_0010, 32'h0000_0005);   // Opposite signs
	endtask

	task automatic run_shift_set(input logic [4:0] amt);
		logic [31:0] a, b, c;
		a = $urandom | 32'h8000_0000;            // Sign bit set for SRA
		b = ($urandom & 32'hffff_ffe0) | amt;
		c = ($urandom & 32'hffff_ffe0) | {27'd0, ~amt};   // rs2 unlike the immediate
		run_check(r_type(7'b0000000, 3'b001), OP_SLL, a, b, "SLL");
		run_check(r_type(7'b0000000, 3'b101), OP_SRL, a, b, "SRL");
		run_check(r_type(7'b0100000, 3'b101), OP_SRA, a, b, "SRA");
		run_check(r_type(7'b0110000, 3'b001), OP_ROL, a, b, "ROL");
		run_check(r_type(7'b0110000, 3'b101), OP_ROR, a, b, "ROR");
		run_check(i_type(7'b0000000, amt, 3'b001), OP_SLL, a, c, "SLLI");
		run_check(i_type(7'b0000000, amt, 3'b101), OP_SRL, a, c, "SRLI");
		run_check(i_type(7'b0100000, amt, 3'b101), OP_SRA, a, c, "SRAI");
		run_check(i_type(7'b0110000, amt, 3'b101), OP_ROR, a, c, "RORI");
	endtask

	task automatic test_shift();
		run_shift_set(5'd0);
		run_shift_set(5'd31);
		run_shift_set($urandom % 32);
	endtask

	task automatic test_count();
		logic [31:0] words [N_WORDS];
		int          k;
		words[0] = 32'h0000_0000;
		words[1] = 32'hffff_ffff;
		words[2] = 32'h0000_0001;
		words[3] = 32'h0000_1000;
		words[4] = 32'h8000_0000;
		for (k = 5; k < N_WORDS; k++)
			words[k] = $urandom >> ($urandom % 32);
		for (k = 0; k < N_WORDS; k++) begin
			run_check(i_type(7'b0110000, 5'd0, 3'b001), OP_CLZ, words[k], $urandom, "CLZ");
			run_check(i_type(7'b0110000, 5'd1, 3'b001), OP_CTZ, words[k], $urandom, "CTZ");
			run_check(i_type(7'b0110000, 5'd2, 3'b001), OP_PCNT, words[k], $urandom, "PCNT");
		end
	endtask

	// Second instruction waits in its unit behind a stalled output
	task automatic test_backpressure();
		logic [31:0] a, b, c, rd, exp1, exp2;
		a = $urandom >> 9;
		b = $urandom;
		c = $urandom;
		exp1 = expected_result(OP_CLZ, a, 32'd0);
		exp2 = expected_result(OP_ANDN, b, c);
		@(posedge clock);
		dout_ready <= 1'b0;
		send_insn(i_type(7'b0110000, 5'd0, 3'b001), a, 32'd0);
		wait_result(rd);
		check_equal("CLZ under back-pressure", rd, exp1);
		send_insn(r_type(7'b0100000, 3'b111), b, c);
		repeat (6) begin
			@(negedge clock);
			check_equal("dout_valid while stalled", dout_valid, 1'b1);
			check_equal("dout_rd while stalled", dout_rd, exp1);
			check_equal("din_ready while stalled", din_ready, 1'b0);
		end
		@(posedge clock);
		dout_ready <= 1'b1;
		@(posedge clock);
		@(negedge clock);
		check_equal("dout_valid after release", dout_valid, 1'b1);
		check_equal("ANDN after release", dout_rd, exp2);
		@(negedge clock);
		check_equal("dout_valid after transfer", dout_valid, 1'b0);
	endtask

	task automatic test_undefined();
		@(posedge clock);
		din_valid <= 1'b1;
		din_insn <= i_type(7'b0110000, 5'b10000, 3'b001);   // CRC32.B encoding
		din_rs1 <= $urandom;
		repeat (10) begin
			@(negedge clock);
			check_equal("din_decoded on undefined insn", din_decoded, 1'b0);
			check_equal("din_ready on undefined insn", din_ready, 1'b0);
			check_equal("dout_valid on undefined insn", dout_valid, 1'b0);
		end
		@(posedge clock);
		din_valid <= 1'b0;
	endtask

	task automatic test_back_to_back();
		logic [31:0] a, b, c, rd, exp1, exp2;
		a = $urandom;
		b = $urandom;
		c = $urandom;
		exp1 = expected_result(OP_PCNT, a, 32'd0);
		exp2 = expected_result(OP_XNOR, b, c);
		send_insn(i_type(7'b0110000, 5'd2, 3'b001), a, 32'd0);
		din_valid <= 1'b1;                       // Second follows without a gap
		din_insn <= r_type(7'b0100000, 3'b100);
		din_rs1 <= b;
		din_rs2 <= c;
		@(negedge clock);
		while (!dout_valid) begin
			check_equal("din_ready before first capture", din_ready, 1'b0);
			@(negedge clock);
		end
		check_equal("first of two", dout_rd, exp1);
		while (!din_ready)
			@(negedge clock);
		@(posedge clock);
		din_valid <= 1'b0;
		wait_result(rd);
		check_equal("second of two", rd, exp2);
	endtask

	initial begin
		void'($urandom(32'h47e3));
		clock = 1'b0;
		reset = 1'b1;
		din_valid = 1'b0;
		din_insn = '0;
		din_rs1 = '0;
		din_rs2 = '0;
		dout_ready = 1'b1;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		test_logic();
		test_shift();
		test_count();
		test_backpressure();
		test_undefined();
		test_back_to_back();
		@(posedge clock);
		if (u_dut.u_checker.fail_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("Bound checker reported %0d assertion failures", u_dut.u_checker.fail_count);
			$display("SOME TESTS FAILED");
			$fatal(1, "Assertion failures");
		end
	end

	initial begin
		repeat (CYCLES_PER_TEST * N_TESTS) @(posedge clock);
		$display("Watchdog expired, the run hung waiting on the DUT");
		$display("SOME TESTS FAILED");
		$fatal(1, "Timeout");
	end

endmodule

`default_nettype wire

//--- project.f
hw/bitmanip_pkg.sv
hw/unit_if.sv
hw/insn_decoder.sv
hw/issue_stage.sv
hw/logic_unit.sv
hw/shift_unit.sv
hw/count_unit.sv
hw/result_stage.sv
hw/bitmanip_top.sv
testbench/bitmanip_checker.sv
testbench/bitmanip_tb.sv

//--- Bender.yml
package:
  name: bitmanip_coprocessor

sources:
  - hw/bitmanip_pkg.sv
  - hw/unit_if.sv
  - hw/insn_decoder.sv
  - hw/issue_stage.sv
  - hw/logic_unit.sv
  - hw/shift_unit.sv
  - hw/count_unit.sv
  - hw/result_stage.sv
  - hw/bitmanip_top.sv
  - target: test
    files:
      - testbench/bitmanip_checker.sv
      - testbench/bitmanip_tb.sv
